// File: design/inval_filter.sv
`timescale 1ns/1ps

module inval_filter (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                cons_en_i,
  // From the vector unit
  input  mem_pkg::addr_t      slv_addr_i,
  input  logic                slv_we_i,
  input  mem_pkg::word_t      slv_wdata_i,
  input  logic                slv_valid_i,
  output logic                slv_ready_o,
  // Towards the arbiter
  output mem_pkg::addr_t      mst_addr_o,
  output logic                mst_we_o,
  output mem_pkg::word_t      mst_wdata_o,
  output logic                mst_valid_o,
  input  logic                mst_ready_i,
  // Read data
  output mem_pkg::mem_rdata_t slv_rdata_o,
  output logic                slv_rvalid_o,
  input  mem_pkg::mem_rdata_t mst_rdata_i,
  input  logic                mst_rvalid_i,
  // Line reports to the host
  output mem_pkg::addr_t      inval_addr_o,
  output logic                inval_valid_o,
  input  logic                inval_ready_i
);

  import mem_pkg::*;

  line_t line_q;
  logic  line_valid_q;
  line_t slv_line;
  logic  need_inval;
  logic  inval_hs;

  assign slv_line = line_t'(slv_addr_i >> LINE_OFFSET);

  // Write to a line not yet reported
  assign need_inval = cons_en_i && slv_valid_i && slv_we_i &&
                      !(line_valid_q && (line_q == slv_line));

  assign inval_valid_o = need_inval;
  assign inval_addr_o  = {slv_line, {LINE_OFFSET{1'b0}}};
  assign inval_hs      = inval_valid_o && inval_ready_i;

  // Held back until the report goes out
  assign mst_addr_o  = slv_addr_i;
  assign mst_we_o    = slv_we_i;
  assign mst_wdata_o = slv_wdata_i;
  assign mst_valid_o = slv_valid_i && !need_inval;
  assign slv_ready_o = mst_ready_i && !need_inval;

  assign slv_rdata_o  = mst_rdata_i;
  assign slv_rvalid_o = mst_rvalid_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      line_valid_q <= 1'b0;
    end else if (!cons_en_i) begin
      line_valid_q <= 1'b0;
    end else if (inval_hs) begin
      line_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (inval_hs) line_q <= slv_line;
  end

endmodule

// File: design/mem_arbiter.sv
`timescale 1ns/1ps
`include "vec_system_config.svh"

module mem_arbiter (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Port 0
  input  mem_pkg::addr_t      p0_addr_i,
  input  logic                p0_we_i,
  input  mem_pkg::word_t      p0_wdata_i,
  input  logic                p0_valid_i,
  output logic                p0_ready_o,
  output mem_pkg::mem_rdata_t p0_rdata_o,
  output logic                p0_rvalid_o,
  // Port 1
  input  mem_pkg::addr_t      p1_addr_i,
  input  logic                p1_we_i,
  input  mem_pkg::word_t      p1_wdata_i,
  input  logic                p1_valid_i,
  output logic                p1_ready_o,
  output mem_pkg::mem_rdata_t p1_rdata_o,
  output logic                p1_rvalid_o,
  // Memory
  output mem_pkg::addr_t      mem_addr_o,
  output logic                mem_we_o,
  output mem_pkg::word_t      mem_wdata_o,
  output logic                mem_valid_o,
  input  logic                mem_ready_i,
  input  mem_pkg::mem_rdata_t mem_rdata_i,
  input  logic                mem_rvalid_i
);

  import mem_pkg::*;

  localparam int unsigned ORDER_DEPTH = `VS_ORDER_DEPTH;
  localparam int unsigned PTR_WIDTH   = $clog2(ORDER_DEPTH);

  logic                   prio_q;
  logic                   p0_elig;
  logic                   p1_elig;
  logic                   sel;
  logic                   req_valid;
  logic                   req_ready;
  logic                   gnt_hs;
  mem_req_t               req_in;
  mem_req_t               req_out;
  logic [ORDER_DEPTH-1:0] order_q;
  logic [PTR_WIDTH-1:0]   wr_ptr_q;
  logic [PTR_WIDTH-1:0]   rd_ptr_q;
  logic [PTR_WIDTH:0]     count_q;
  logic                   oq_full;
  logic                   oq_push;

  ////////////////////
  // Grant
  ////////////////////

  // No new reads while every order slot is taken
  assign oq_full = (count_q == (PTR_WIDTH+1)'(ORDER_DEPTH));
  assign p0_elig = p0_valid_i && (p0_we_i || !oq_full);
  assign p1_elig = p1_valid_i && (p1_we_i || !oq_full);

  // prio_q picks the winner only when both ask
  assign sel       = (p0_elig && p1_elig) ? prio_q : p1_elig;
  assign req_valid = p0_elig || p1_elig;
  assign gnt_hs    = req_valid && req_ready;

  assign p0_ready_o = req_ready && p0_elig && !sel;
  assign p1_ready_o = req_ready && p1_elig && sel;

  always_comb begin
    if (sel) begin
      req_in = '{addr: p1_addr_i, we: p1_we_i, wdata: p1_wdata_i};
    end else begin
      req_in = '{addr: p0_addr_i, we: p0_we_i, wdata: p0_wdata_i};
    end
  end

  spill_reg #(
    .data_t(mem_req_t)
  ) u_req_spill (
    .clk_i  (clk_i      ),
    .rst_n_i(rst_n_i    ),
    .valid_i(req_valid  ),
    .ready_o(req_ready  ),
    .data_i (req_in     ),
    .valid_o(mem_valid_o),
    .ready_i(mem_ready_i),
    .data_o (req_out    )
  );

  assign mem_addr_o  = req_out.addr;
  assign mem_we_o    = req_out.we;
  assign mem_wdata_o = req_out.wdata;

  ////////////////////
  // Read order queue
  ////////////////////

  assign oq_push = gnt_hs && !req_in.we;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      prio_q   <= 1'b0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (gnt_hs) prio_q <= !sel;
      if (oq_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (mem_rvalid_i) rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + (PTR_WIDTH+1)'(oq_push) - (PTR_WIDTH+1)'(mem_rvalid_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (oq_push) order_q[wr_ptr_q] <= sel;
  end

  // Oldest read owns the returning word
  assign p0_rdata_o  = mem_rdata_i;
  assign p1_rdata_o  = mem_rdata_i;
  assign p0_rvalid_o = mem_rvalid_i && !order_q[rd_ptr_q];
  assign p1_rvalid_o = mem_rvalid_i && order_q[rd_ptr_q];

endmodule

// File: design/mem_pkg.sv
`include "vec_system_config.svh"

package mem_pkg;

  typedef logic [`VS_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`VS_DATA_WIDTH-1:0] word_t;

  // Byte offset bits inside one cache line
  localparam int unsigned LINE_OFFSET = $clog2(`VS_LINE_BYTES);
  typedef logic [`VS_ADDR_WIDTH-LINE_OFFSET-1:0] line_t;

  // One word access with don't-care wdata on reads
  typedef struct packed {
    addr_t addr;
    logic  we;
    word_t wdata;
  } mem_req_t;

  // Read data returns in request order
  typedef word_t mem_rdata_t;

endpackage

// File: design/spill_reg.sv
`timescale 1ns/1ps

module spill_reg #(
  parameter type data_t = logic
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  valid_i,
  output logic  ready_o,
  input  data_t data_i,
  output logic  valid_o,
  input  logic  ready_i,
  output data_t data_o
);

  // Slot a takes new data, slot b catches it when the output stalls
  logic  a_full_q;
  logic  b_full_q;
  data_t a_data_q;
  data_t b_data_q;
  logic  a_fill;
  logic  a_drain;
  logic  b_fill;
  logic  b_drain;

  assign a_fill  = valid_i && ready_o;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) a_full_q <= a_fill;
      if (b_fill || b_drain) b_full_q <= b_fill;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) a_data_q <= data_i;
    if (b_fill) b_data_q <= a_data_q;
  end

  // Ready only looks at local state
  assign ready_o = !a_full_q || !b_full_q;
  assign valid_o = a_full_q || b_full_q;
  // b always holds the older entry
  assign data_o  = b_full_q ? b_data_q : a_data_q;

endmodule

// File: design/vec_pkg.sv
`include "vec_system_config.svh"

package vec_pkg;

  // Vector command opcodes
  typedef enum logic [1:0] {
    VEC_LOAD_SUM    = 2'd0,
    VEC_STORE_SPLAT = 2'd1,
    VEC_STORE_RAMP  = 2'd2
  } vec_op_e;

  // Wide enough for VS_MAX_VLEN itself
  localparam int unsigned VLEN_WIDTH = $clog2(`VS_MAX_VLEN + 1);
  typedef logic [VLEN_WIDTH-1:0] vlen_t;

  typedef struct packed {
    vec_op_e                   op;
    logic [`VS_ADDR_WIDTH-1:0] addr;
    vlen_t                     vlen;
    logic [`VS_DATA_WIDTH-1:0] operand;
  } acc_req_t;

  // Sum for a load, zero for a store
  typedef struct packed {
    logic [`VS_DATA_WIDTH-1:0] result;
  } acc_resp_t;

endpackage

// File: design/vec_system.sv
`timescale 1ns/1ps

module vec_system (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Host command and response
  input  vec_pkg::vec_op_e    acc_req_op_i,
  input  mem_pkg::addr_t      acc_req_addr_i,
  input  vec_pkg::vlen_t      acc_req_vlen_i,
  input  mem_pkg::word_t      acc_req_operand_i,
  input  logic                acc_req_valid_i,
  output logic                acc_req_ready_o,
  output mem_pkg::word_t      acc_resp_result_o,
  output logic                acc_resp_valid_o,
  input  logic                acc_resp_ready_i,
  input  logic                acc_cons_en_i,
  // Scalar memory port
  input  mem_pkg::addr_t      scalar_req_addr_i,
  input  logic                scalar_req_we_i,
  input  mem_pkg::word_t      scalar_req_wdata_i,
  input  logic                scalar_req_valid_i,
  output logic                scalar_req_ready_o,
  output mem_pkg::mem_rdata_t scalar_rdata_o,
  output logic                scalar_rvalid_o,
  // Invalidations
  output mem_pkg::addr_t      inval_addr_o,
  output logic                inval_valid_o,
  input  logic                inval_ready_i,
  // External memory
  output mem_pkg::addr_t      mem_req_addr_o,
  output logic                mem_req_we_o,
  output mem_pkg::word_t      mem_req_wdata_o,
  output logic                mem_req_valid_o,
  input  logic                mem_req_ready_i,
  input  mem_pkg::mem_rdata_t mem_rdata_i,
  input  logic                mem_rvalid_i
);

  import mem_pkg::*;

  // Vector unit to filter
  addr_t      vmem_addr;
  logic       vmem_we;
  word_t      vmem_wdata;
  logic       vmem_valid;
  logic       vmem_ready;
  mem_rdata_t vmem_rdata;
  logic       vmem_rvalid;

  // Filter to arbiter port 0
  addr_t      filt_addr;
  logic       filt_we;
  word_t      filt_wdata;
  logic       filt_valid;
  logic       filt_ready;
  mem_rdata_t filt_rdata;
  logic       filt_rvalid;

  ////////////////////
  // Vector unit
  ////////////////////

  vec_unit u_vec_unit (
    .clk_i            (clk_i            ),
    .rst_n_i          (rst_n_i          ),
    .acc_req_op_i     (acc_req_op_i     ),
    .acc_req_addr_i   (acc_req_addr_i   ),
    .acc_req_vlen_i   (acc_req_vlen_i   ),
    .acc_req_operand_i(acc_req_operand_i),
    .acc_req_valid_i  (acc_req_valid_i  ),
    .acc_req_ready_o  (acc_req_ready_o  ),
    .acc_resp_result_o(acc_resp_result_o),
    .acc_resp_valid_o (acc_resp_valid_o ),
    .acc_resp_ready_i (acc_resp_ready_i ),
    .vmem_addr_o      (vmem_addr        ),
    .vmem_we_o        (vmem_we          ),
    .vmem_wdata_o     (vmem_wdata       ),
    .vmem_valid_o     (vmem_valid       ),
    .vmem_ready_i     (vmem_ready       ),
    .vmem_rdata_i     (vmem_rdata       ),
    .vmem_rvalid_i    (vmem_rvalid      )
  );

  inval_filter u_inval_filter (
    .clk_i        (clk_i        ),
    .rst_n_i      (rst_n_i      ),
    .cons_en_i    (acc_cons_en_i),
    .slv_addr_i   (vmem_addr    ),
    .slv_we_i     (vmem_we      ),
    .slv_wdata_i  (vmem_wdata   ),
    .slv_valid_i  (vmem_valid   ),
    .slv_ready_o  (vmem_ready   ),
    .mst_addr_o   (filt_addr    ),
    .mst_we_o     (filt_we      ),
    .mst_wdata_o  (filt_wdata   ),
    .mst_valid_o  (filt_valid   ),
    .mst_ready_i  (filt_ready   ),
    .slv_rdata_o  (vmem_rdata   ),
    .slv_rvalid_o (vmem_rvalid  ),
    .mst_rdata_i  (filt_rdata   ),
    .mst_rvalid_i (filt_rvalid  ),
    .inval_addr_o (inval_addr_o ),
    .inval_valid_o(inval_valid_o),
    .inval_ready_i(inval_ready_i)
  );

  ////////////////////
  // Memory arbiter
  ////////////////////

  mem_arbiter u_mem_arbiter (
    .clk_i       (clk_i             ),
    .rst_n_i     (rst_n_i           ),
    .p0_addr_i   (filt_addr         ),
    .p0_we_i     (filt_we           ),
    .p0_wdata_i  (filt_wdata        ),
    .p0_valid_i  (filt_valid        ),
    .p0_ready_o  (filt_ready        ),
    .p0_rdata_o  (filt_rdata        ),
    .p0_rvalid_o (filt_rvalid       ),
    .p1_addr_i   (scalar_req_addr_i ),
    .p1_we_i     (scalar_req_we_i   ),
    .p1_wdata_i  (scalar_req_wdata_i),
    .p1_valid_i  (scalar_req_valid_i),
    .p1_ready_o  (scalar_req_ready_o),
    .p1_rdata_o  (scalar_rdata_o    ),
    .p1_rvalid_o (scalar_rvalid_o   ),
    .mem_addr_o  (mem_req_addr_o    ),
    .mem_we_o    (mem_req_we_o      ),
    .mem_wdata_o (mem_req_wdata_o   ),
    .mem_valid_o (mem_req_valid_o   ),
    .mem_ready_i (mem_req_ready_i   ),
    .mem_rdata_i (mem_rdata_i       ),
    .mem_rvalid_i(mem_rvalid_i      )
  );

endmodule

// File: design/vec_unit.sv
`timescale 1ns/1ps

module vec_unit (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Host command and response
  input  vec_pkg::vec_op_e    acc_req_op_i,
  input  mem_pkg::addr_t      acc_req_addr_i,
  input  vec_pkg::vlen_t      acc_req_vlen_i,
  input  mem_pkg::word_t      acc_req_operand_i,
  input  logic                acc_req_valid_i,
  output logic                acc_req_ready_o,
  output mem_pkg::word_t      acc_resp_result_o,
  output logic                acc_resp_valid_o,
  input  logic                acc_resp_ready_i,
  // Word accesses
  output mem_pkg::addr_t      vmem_addr_o,
  output logic                vmem_we_o,
  output mem_pkg::word_t      vmem_wdata_o,
  output logic                vmem_valid_o,
  input  logic                vmem_ready_i,
  input  mem_pkg::mem_rdata_t vmem_rdata_i,
  input  logic                vmem_rvalid_i
);

  import vec_pkg::*;
  import mem_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_DRAIN,
    ST_RESP
  } state_e;

  state_e    state_q;
  acc_req_t  cmd_q;
  vlen_t     idx_q;
  vlen_t     outst_q;
  word_t     sum_q;
  logic      cmd_hs;
  logic      issue_hs;
  logic      last_elem;
  acc_resp_t resp;
  acc_resp_t resp_out;
  logic      resp_valid;
  logic      resp_ready;

  assign cmd_hs    = acc_req_valid_i && acc_req_ready_o;
  assign issue_hs  = vmem_valid_o && vmem_ready_i;
  assign last_elem = (idx_q == cmd_q.vlen - vlen_t'(1));

  assign acc_req_ready_o = (state_q == ST_IDLE);

  ////////////////////
  // Element issue
  ////////////////////

  assign vmem_valid_o = (state_q == ST_ISSUE);
  assign vmem_we_o    = (cmd_q.op != VEC_LOAD_SUM);
  assign vmem_addr_o  = cmd_q.addr + (addr_t'(idx_q) << 2);
  assign vmem_wdata_o = (cmd_q.op == VEC_STORE_RAMP) ? cmd_q.operand + word_t'(idx_q)
                                                     : cmd_q.operand;

  always_ff @(posedge clk_i) begin
    if (cmd_hs) begin
      cmd_q <= '{op: acc_req_op_i, addr: acc_req_addr_i, vlen: acc_req_vlen_i,
                 operand: acc_req_operand_i};
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      idx_q   <= '0;
      outst_q <= '0;
      sum_q   <= '0;
    end else begin
      // Count of reads still in flight
      outst_q <= outst_q + vlen_t'(issue_hs && !vmem_we_o) - vlen_t'(vmem_rvalid_i);
      if (vmem_rvalid_i) sum_q <= sum_q + vmem_rdata_i;
      unique case (state_q)
        ST_IDLE: begin
          if (cmd_hs) begin
            idx_q   <= '0;
            sum_q   <= '0;
            state_q <= ST_ISSUE;
          end
        end
        ST_ISSUE: begin
          if (issue_hs) begin
            idx_q <= idx_q + vlen_t'(1);
            if (last_elem) state_q <= vmem_we_o ? ST_RESP : ST_DRAIN;
          end
        end
        ST_DRAIN: begin
          if (outst_q == '0) state_q <= ST_RESP;
        end
        default: begin
          if (resp_ready) state_q <= ST_IDLE;
        end
      endcase
    end
  end

  ////////////////////
  // Response
  ////////////////////

  assign resp_valid  = (state_q == ST_RESP);
  assign resp.result = (cmd_q.op == VEC_LOAD_SUM) ? sum_q : '0;

  spill_reg #(
    .data_t(acc_resp_t)
  ) u_resp_spill (
    .clk_i  (clk_i           ),
    .rst_n_i(rst_n_i         ),
    .valid_i(resp_valid      ),
    .ready_o(resp_ready      ),
    .data_i (resp            ),
    .valid_o(acc_resp_valid_o),
    .ready_i(acc_resp_ready_i),
    .data_o (resp_out        )
  );

  assign acc_resp_result_o = resp_out.result;

endmodule

// File: include/vec_system_config.svh
`ifndef VEC_SYSTEM_CONFIG_SVH
`define VEC_SYSTEM_CONFIG_SVH

// Byte address and memory word
`define VS_ADDR_WIDTH 32
`define VS_DATA_WIDTH 32

// Four words per line
`define VS_LINE_BYTES 16

// Vector length limit and read tracking depth
`define VS_MAX_VLEN 8
`define VS_ORDER_DEPTH 4

`endif

// File: run.sh
#!/bin/sh
# Build and run the vec_system testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f vec_system.f \
  --top-module tb_vec_system -o tb_vec_system

out=$(./obj_dir/tb_vec_system 2>&1) || true
echo "$out"

if echo "$out" | grep -q "TESTBENCH PASSED"; then
  exit 0
fi
exit 1

// File: vec_system.f
+incdir+include
design/vec_pkg.sv
design/mem_pkg.sv
design/spill_reg.sv
design/vec_unit.sv
design/inval_filter.sv
design/mem_arbiter.sv
design/vec_system.sv
verif/tb_mem_model.sv
verif/tb_vec_system.sv

// File: verif/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  mem_pkg::addr_t      req_addr_i,
  input  logic                req_we_i,
  input  mem_pkg::word_t      req_wdata_i,
  input  logic                req_valid_i,
  input  logic                req_ready_i,
  output mem_pkg::mem_rdata_t rdata_o,
  output logic                rvalid_o
);

  import mem_pkg::*;

  localparam int unsigned MEM_WORDS = 64;
  localparam int unsigned LATENCY   = 2;

  word_t              mem [MEM_WORDS];
  logic [LATENCY-1:0] pipe_valid_q;
  word_t              pipe_data_q [LATENCY];
  int unsigned        idx;
  logic               req_hs;

  assign idx    = (req_addr_i >> 2) % MEM_WORDS;
  assign req_hs = req_valid_i && req_ready_i;

  // Reset loads the fill pattern, reads come back after a fixed delay
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      pipe_valid_q <= '0;
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= 32'hC0DE_0000 ^ (i * 32'h9E37_79B1);
      end
    end else begin
      pipe_valid_q[0] <= req_hs && !req_we_i;
      pipe_data_q[0]  <= mem[idx];
      for (int i = 1; i < LATENCY; i++) begin
        pipe_valid_q[i] <= pipe_valid_q[i-1];
        pipe_data_q[i]  <= pipe_data_q[i-1];
      end
      if (req_hs && req_we_i) begin
        mem[idx] <= req_wdata_i;
      end
    end
  end

  assign rvalid_o = pipe_valid_q[LATENCY-1];
  assign rdata_o  = pipe_data_q[LATENCY-1];

endmodule

// File: verif/tb_vec_system.sv
`timescale 1ns/1ps
`include "vec_system_config.svh"

module tb_vec_system;

  import vec_pkg::*;
  import mem_pkg::*;

  localparam int unsigned MEM_WORDS    = 64;
  localparam int unsigned NUM_ROWS     = 13;
  localparam int unsigned SCALAR_READS = 2;
  localparam int unsigned TIMEOUT      = 1000;

  typedef struct packed {
    vec_op_e    op;
    addr_t      addr;
    vlen_t      vlen;
    word_t      operand;
    logic       cons_en;
    logic [3:0] exp_inval;
  } row_t;

  // op, base address, vlen, operand, coherence enable, invalidations
  row_t rows [NUM_ROWS] = '{
    '{VEC_LOAD_SUM,    32'h00, 4'd8, 32'h0000_0000, 1'b1, 4'd0},
    '{VEC_STORE_SPLAT, 32'h08, 4'd8, 32'h1111_1111, 1'b1, 4'd3},
    '{VEC_LOAD_SUM,    32'h08, 4'd8, 32'h0000_0000, 1'b1, 4'd0},
    '{VEC_STORE_SPLAT, 32'h24, 4'd3, 32'hDEAD_BEEF, 1'b1, 4'd0},
    '{VEC_STORE_RAMP,  32'h40, 4'd8, 32'hFFFF_FFFC, 1'b1, 4'd2},
    '{VEC_LOAD_SUM,    32'h40, 4'd8, 32'h0000_0000, 1'b1, 4'd0},
    '{VEC_STORE_RAMP,  32'h84, 4'd5, 32'h0000_0100, 1'b0, 4'd0},
    '{VEC_LOAD_SUM,    32'h80, 4'd8, 32'h0000_0000, 1'b0, 4'd0},
    '{VEC_STORE_SPLAT, 32'h84, 4'd1, 32'h0000_0007, 1'b1, 4'd1},
    '{VEC_STORE_SPLAT, 32'h88, 4'd2, 32'h0000_0009, 1'b1, 4'd0},
    '{VEC_LOAD_SUM,    32'h80, 4'd4, 32'h0000_0000, 1'b1, 4'd0},
    '{VEC_STORE_RAMP,  32'hF0, 4'd4, 32'h8000_0000, 1'b1, 4'd1},
    '{VEC_LOAD_SUM,    32'hE0, 4'd8, 32'h0000_0000, 1'b0, 4'd0}
  };

  logic       clk = 1'b0;
  logic       rst_n;
  vec_op_e    acc_req_op;
  addr_t      acc_req_addr;
  vlen_t      acc_req_vlen;
  word_t      acc_req_operand;
  logic       acc_req_valid;
  logic       acc_req_ready;
  word_t      acc_resp_result;
  logic       acc_resp_valid;
  logic       acc_resp_ready;
  logic       acc_cons_en;
  addr_t      scalar_addr;
  logic       scalar_we;
  word_t      scalar_wdata;
  logic       scalar_valid;
  logic       scalar_ready;
  mem_rdata_t scalar_rdata;
  logic       scalar_rvalid;
  addr_t      inval_addr;
  logic       inval_valid;
  logic       inval_ready;
  addr_t      mem_addr;
  logic       mem_we;
  word_t      mem_wdata;
  logic       mem_valid;
  logic       mem_ready;
  mem_rdata_t mem_rdata;
  logic       mem_rvalid;

  logic [15:0] lfsr_q;
  row_t        cur;
  word_t       cmd_result;
  word_t       ref_mem [MEM_WORDS];
  logic        ref_line_valid;
  addr_t       ref_line;
  addr_t       inval_exp_q [$];
  addr_t       inval_q [$];
  word_t       resp_q [$];
  word_t       scalar_q [$];

  vec_system u_vec_system (
    .clk_i             (clk            ),
    .rst_n_i           (rst_n          ),
    .acc_req_op_i      (acc_req_op     ),
    .acc_req_addr_i    (acc_req_addr   ),
    .acc_req_vlen_i    (acc_req_vlen   ),
    .acc_req_operand_i (acc_req_operand),
    .acc_req_valid_i   (acc_req_valid  ),
    .acc_req_ready_o   (acc_req_ready  ),
    .acc_resp_result_o (acc_resp_result),
    .acc_resp_valid_o  (acc_resp_valid ),
    .acc_resp_ready_i  (acc_resp_ready ),
    .acc_cons_en_i     (acc_cons_en    ),
    .scalar_req_addr_i (scalar_addr    ),
    .scalar_req_we_i   (scalar_we      ),
    .scalar_req_wdata_i(scalar_wdata   ),
    .scalar_req_valid_i(scalar_valid   ),
    .scalar_req_ready_o(scalar_ready   ),
    .scalar_rdata_o    (scalar_rdata   ),
    .scalar_rvalid_o   (scalar_rvalid  ),
    .inval_addr_o      (inval_addr     ),
    .inval_valid_o     (inval_valid    ),
    .inval_ready_i     (inval_ready    ),
    .mem_req_addr_o    (mem_addr       ),
    .mem_req_we_o      (mem_we         ),
    .mem_req_wdata_o   (mem_wdata      ),
    .mem_req_valid_o   (mem_valid      ),
    .mem_req_ready_i   (mem_ready      ),
    .mem_rdata_i       (mem_rdata      ),
    .mem_rvalid_i      (mem_rvalid     )
  );

  tb_mem_model u_mem_model (
    .clk_i      (clk      ),
    .rst_n_i    (rst_n    ),
    .req_addr_i (mem_addr ),
    .req_we_i   (mem_we   ),
    .req_wdata_i(mem_wdata),
    .req_valid_i(mem_valid),
    .req_ready_i(mem_ready),
    .rdata_o    (mem_rdata),
    .rvalid_o   (mem_rvalid)
  );

  initial begin
    forever #50 clk = ~clk;
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic stop_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped after an error");
  endtask

  task automatic check_value(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out at %0t ns while waiting for %s", $time, what);
    stop_run();
  endtask

  // Galois LFSR stepped once per bit
  function automatic logic take_bit();
    logic b;
    b = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (b) begin
      lfsr_q = lfsr_q ^ 16'hB400;
    end
    return b;
  endfunction

  function automatic int unsigned take_bits(input int unsigned n);
    int unsigned v;
    v = 0;
    for (int unsigned k = 0; k < n; k++) begin
      v = (v << 1) | 32'(take_bit());
    end
    return v;
  endfunction

  function automatic int unsigned word_index(input addr_t a);
    return (a >> 2) % MEM_WORDS;
  endfunction

  function automatic word_t expected_result();
    word_t sum;
    sum = '0;
    if (cur.op == VEC_LOAD_SUM) begin
      for (int i = 0; i < int'(cur.vlen); i++) begin
        sum = sum + ref_mem[word_index(cur.addr + addr_t'(4 * i))];
      end
    end
    return sum;
  endfunction

  // One report per newly touched line while coherence is on
  function automatic void predict_invals();
    addr_t line;
    if (!cur.cons_en) begin
      ref_line_valid = 1'b0;
    end else if (cur.op != VEC_LOAD_SUM) begin
      for (int i = 0; i < int'(cur.vlen); i++) begin
        line = (cur.addr + addr_t'(4 * i)) & ~addr_t'(`VS_LINE_BYTES - 1);
        if (!ref_line_valid || line != ref_line) begin
          inval_exp_q.push_back(line);
          ref_line       = line;
          ref_line_valid = 1'b1;
        end
      end
    end
  endfunction

  function automatic void apply_store();
    for (int i = 0; i < int'(cur.vlen); i++) begin
      if (cur.op == VEC_STORE_SPLAT) begin
        ref_mem[word_index(cur.addr + addr_t'(4 * i))] = cur.operand;
      end else if (cur.op == VEC_STORE_RAMP) begin
        ref_mem[word_index(cur.addr + addr_t'(4 * i))] = cur.operand + word_t'(i);
      end
    end
  endfunction

  ////////////////////
  // Host behavior
  ////////////////////

  task automatic issue_command();
    int unsigned cycles;
    logic        accepted;
    @(negedge clk);
    acc_req_op      = cur.op;
    acc_req_addr    = cur.addr;
    acc_req_vlen    = cur.vlen;
    acc_req_operand = cur.operand;
    acc_cons_en     = cur.cons_en;
    acc_req_valid   = 1'b1;
    cycles   = 0;
    accepted = 1'b0;
    while (!accepted) begin
      @(posedge clk);
      accepted = acc_req_ready;
      cycles++;
      if (cycles > TIMEOUT) report_timeout("the command to be accepted");
    end
    @(negedge clk);
    acc_req_valid = 1'b0;
    cycles = 0;
    while (resp_q.size() == 0) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) report_timeout("the command response");
    end
    cmd_result = resp_q.pop_front();
  endtask

  // Scalar reads stay clear of the words the running store writes
  task automatic scalar_reads();
    int unsigned gap;
    int unsigned word;
    int unsigned base;
    int unsigned cycles;
    logic        granted;
    word_t       exp;
    base = word_index(cur.addr);
    for (int n = 0; n < SCALAR_READS; n++) begin
      @(posedge clk);
      gap  = take_bits(2);
      word = take_bits(6);
      if (cur.op != VEC_LOAD_SUM && word >= base && word < base + int'(cur.vlen)) begin
        word = word ^ 32;
      end
      exp = ref_mem[word];
      repeat (gap) @(negedge clk);
      @(negedge clk);
      scalar_addr  = addr_t'(word << 2);
      scalar_valid = 1'b1;
      cycles  = 0;
      granted = 1'b0;
      while (!granted) begin
        @(posedge clk);
        granted = scalar_ready;
        cycles++;
        if (cycles > TIMEOUT) report_timeout("a scalar request grant");
      end
      @(negedge clk);
      scalar_valid = 1'b0;
      cycles = 0;
      while (scalar_q.size() == 0) begin
        @(negedge clk);
        cycles++;
        if (cycles > TIMEOUT) report_timeout("scalar read data");
      end
      check_value("scalar read data", scalar_q.pop_front(), exp);
    end
  endtask

  // Random back-pressure
  always @(negedge clk) begin
    mem_ready      = take_bit() | take_bit();
    inval_ready    = take_bit() | take_bit();
    acc_resp_ready = take_bit();
  end

  // Transfers seen at the rising edge
  always @(posedge clk) begin
    if (rst_n) begin
      if (acc_resp_valid && acc_resp_ready) resp_q.push_back(acc_resp_result);
      if (inval_valid && inval_ready) inval_q.push_back(inval_addr);
      if (scalar_rvalid) scalar_q.push_back(scalar_rdata);
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    word_t exp_result;
    acc_req_op      = VEC_LOAD_SUM;
    acc_req_addr    = '0;
    acc_req_vlen    = '0;
    acc_req_operand = '0;
    acc_req_valid   = 1'b0;
    acc_resp_ready  = 1'b0;
    acc_cons_en     = 1'b0;
    scalar_addr     = '0;
    scalar_we       = 1'b0;
    scalar_wdata    = '0;
    scalar_valid    = 1'b0;
    inval_ready     = 1'b0;
    mem_ready       = 1'b0;
    lfsr_q          = 16'd40508;
    ref_line_valid  = 1'b0;
    ref_line        = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = 32'hC0DE_0000 ^ (i * 32'h9E37_79B1);
    end
    rst_n = 1'b0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("acc_resp_valid_o after reset", 32'(acc_resp_valid), 32'd0);
    check_value("mem_req_valid_o after reset", 32'(mem_valid), 32'd0);
    check_value("inval_valid_o after reset", 32'(inval_valid), 32'd0);
    check_value("scalar_rvalid_o after reset", 32'(scalar_rvalid), 32'd0);
    check_value("acc_req_ready_o after reset", 32'(acc_req_ready), 32'd1);

    for (int r = 0; r < NUM_ROWS; r++) begin
      cur        = rows[r];
      exp_result = expected_result();
      predict_invals();
      check_value($sformatf("row %0d line rule count", r), 32'(inval_exp_q.size()),
                  32'(cur.exp_inval));
      fork
        issue_command();
        scalar_reads();
      join
      check_value($sformatf("row %0d result", r), cmd_result, exp_result);
      check_value($sformatf("row %0d invalidation count", r), 32'(inval_q.size()),
                  32'(cur.exp_inval));
      while (inval_exp_q.size() > 0) begin
        check_value($sformatf("row %0d invalidation address", r), inval_q.pop_front(),
                    inval_exp_q.pop_front());
      end
      apply_store();
    end

    // Nothing extra may show up once traffic stops
    repeat (20) @(negedge clk);
    check_value("extra command responses", 32'(resp_q.size()), 32'd0);
    check_value("extra invalidations", 32'(inval_q.size()), 32'd0);
    check_value("extra scalar read data", 32'(scalar_q.size()), 32'd0);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule
